// File: Makefile
# Verilator build and run for the csc register file

TOP := tb_csc_regfile

.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/100ps -f csc_regfile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TESTBENCH FAILED" sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f csc_regfile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: csc_regfile.f
+incdir+logic
logic/csc_regfile_pkg.sv
logic/csc_csb_port.sv
logic/csc_reg_access.sv
logic/csc_single_reg.sv
logic/csc_dual_reg.sv
logic/csc_group_ctrl.sv
logic/csc_regfile.sv
testbench/tb_csc_regfile.sv

// File: logic/csc_csb_port.sv
// CSB port of the csc register file
// captures one request per strobe and answers reads and
// non-posted writes one cycle after the register access
`default_nettype none
`timescale 1ns/100ps
`include "csc_regfile_macros.svh"

module csc_csb_port (
  input  wire                                nvdla_core_clk,
  input  wire                                nvdla_core_rstn,
  input  wire                                csb2csc_req_pvld,
  input  wire csc_regfile_pkg::csb_req_pd_t  csb2csc_req_pd,
  input  wire csc_regfile_pkg::reg_data_t    reg_rd_data,
  output csc_regfile_pkg::reg_offset_t       reg_offset,
  output csc_regfile_pkg::reg_data_t         reg_wr_data,
  output logic                               reg_wr_en,
  output logic                               csc2csb_resp_valid,
  output csc_regfile_pkg::csb_resp_pd_t      csc2csb_resp_pd
);

  logic                          req_pvld;
  logic [21:0]                   req_addr;
  csc_regfile_pkg::reg_data_t    req_wdat;
  logic                          req_write;
  logic                          req_nposted;
  logic                          rd_en;
  logic                          wr_ack_en;
  csc_regfile_pkg::csb_resp_pd_t resp_pd_w;

  ////////////////////
  // request capture
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb2csc_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2csc_req_pvld) begin  // payload only moves with the strobe
      req_addr    <= csb2csc_req_pd[`CSC_REQ_ADDR];
      req_wdat    <= csb2csc_req_pd[`CSC_REQ_WDAT];
      req_write   <= csb2csc_req_pd[`CSC_REQ_WRITE];
      req_nposted <= csb2csc_req_pd[`CSC_REQ_NPOSTED];
    end
  end

  // word address to byte offset
  assign reg_offset  = csc_regfile_pkg::reg_offset_t'({req_addr, 2'b00});
  assign reg_wr_data = req_wdat;
  assign reg_wr_en   = req_pvld & req_write;
  assign rd_en       = req_pvld & ~req_write;
  assign wr_ack_en   = reg_wr_en & req_nposted;  // posted writes stay silent

  ////////////////////
  // response
  always_comb begin
    resp_pd_w = '0;  // error bit never set
    if (req_write) begin
      resp_pd_w[`CSC_RESP_IS_WRITE] = 1'b1;
    end else begin
      resp_pd_w[31:0] = reg_rd_data;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      csc2csb_resp_valid <= 1'b0;
    end else begin
      csc2csb_resp_valid <= rd_en | wr_ack_en;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rd_en | wr_ack_en) begin
      csc2csb_resp_pd <= resp_pd_w;
    end
  end

  // two responses in a row need two strobes in a row, 2 and 3 cycles back
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    csc2csb_resp_valid && $past(csc2csb_resp_valid)
      |-> $past(csb2csc_req_pvld, 2) && $past(csb2csc_req_pvld, 3))
    else $error("csc_csb_port: back to back responses without back to back requests");

endmodule

`default_nettype wire

// File: logic/csc_dual_reg.sv
// one ping-pong configuration group of the csc register file
// field registers, op_en write trigger and read-back
`default_nettype none
`timescale 1ns/100ps
`include "csc_regfile_macros.svh"

module csc_dual_reg (
  input  wire                               nvdla_core_clk,
  input  wire                               nvdla_core_rstn,
  input  wire csc_regfile_pkg::reg_offset_t reg_offset,
  input  wire csc_regfile_pkg::reg_data_t   reg_wr_data,
  input  wire                               wr_en,
  input  wire                               op_en,
  output logic                              op_en_trigger,
  output csc_regfile_pkg::reg_data_t        rd_data,
  output logic                              conv_mode,
  output csc_regfile_pkg::precision_t       in_precision,
  output csc_regfile_pkg::dim_ext_t         datain_width_ext,
  output csc_regfile_pkg::dim_ext_t         datain_height_ext,
  output csc_regfile_pkg::weight_bytes_t    weight_bytes
);

  ////////////////////
  // field registers
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      conv_mode         <= 1'b0;
      in_precision      <= '0;
      datain_width_ext  <= '0;
      datain_height_ext <= '0;
      weight_bytes      <= '0;
    end else if (wr_en) begin
      case (reg_offset)
        `CSC_D_MISC_CFG: begin
          conv_mode    <= reg_wr_data[0];
          in_precision <= reg_wr_data[9:8];
        end
        `CSC_D_DATAIN_SIZE: begin
          datain_width_ext  <= reg_wr_data[12:0];
          datain_height_ext <= reg_wr_data[28:16];
        end
        `CSC_D_WEIGHT_BYTES: weight_bytes <= reg_wr_data[24:0];
        default: ;  // op_en itself lives in the group ctrl
      endcase
    end
  end

  assign op_en_trigger = wr_en & (reg_offset == `CSC_D_OP_ENABLE);

  ////////////////////
  // read-back
  always_comb begin
    case (reg_offset)
      `CSC_D_OP_ENABLE:    rd_data = {31'd0, op_en};
      `CSC_D_MISC_CFG:     rd_data = {22'd0, in_precision, 7'd0, conv_mode};
      `CSC_D_DATAIN_SIZE:  rd_data = {3'd0, datain_height_ext, 3'd0, datain_width_ext};
      `CSC_D_WEIGHT_BYTES: rd_data = {7'd0, weight_bytes};
      default:             rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/csc_group_ctrl.sv
// ping-pong control of the csc register file
// per group op_en, consumer pointer, delayed reg2dp_op_en
// and selection of the active group's fields
`default_nettype none
`timescale 1ns/100ps
`include "csc_regfile_macros.svh"

module csc_group_ctrl (
  input  wire                                nvdla_core_clk,
  input  wire                                nvdla_core_rstn,
  input  wire                                dp2reg_done,
  input  wire csc_regfile_pkg::reg_data_t    reg_wr_data,
  input  wire                                d0_op_en_trigger,
  input  wire                                d1_op_en_trigger,
  input  wire                                d0_conv_mode,
  input  wire csc_regfile_pkg::precision_t   d0_in_precision,
  input  wire csc_regfile_pkg::dim_ext_t     d0_datain_width_ext,
  input  wire csc_regfile_pkg::dim_ext_t     d0_datain_height_ext,
  input  wire csc_regfile_pkg::weight_bytes_t d0_weight_bytes,
  input  wire                                d1_conv_mode,
  input  wire csc_regfile_pkg::precision_t   d1_in_precision,
  input  wire csc_regfile_pkg::dim_ext_t     d1_datain_width_ext,
  input  wire csc_regfile_pkg::dim_ext_t     d1_datain_height_ext,
  input  wire csc_regfile_pkg::weight_bytes_t d1_weight_bytes,
  output logic                               consumer,
  output logic                               d0_op_en,
  output logic                               d1_op_en,
  output logic                               reg2dp_op_en,
  output logic                               reg2dp_conv_mode,
  output csc_regfile_pkg::precision_t        reg2dp_in_precision,
  output csc_regfile_pkg::dim_ext_t          reg2dp_datain_width_ext,
  output csc_regfile_pkg::dim_ext_t          reg2dp_datain_height_ext,
  output csc_regfile_pkg::weight_bytes_t     reg2dp_weight_bytes
);

  logic [1:0]                  op_en;
  logic [1:0]                  op_en_trigger;
  logic                        active_op_en;
  logic [`CSC_OP_EN_DELAY-1:0] op_en_dly;

  assign op_en_trigger = {d1_op_en_trigger, d0_op_en_trigger};

  ////////////////////
  // op_en and consumer
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en    <= '0;
      consumer <= 1'b0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!op_en[i] && op_en_trigger[i]) begin
          op_en[i] <= reg_wr_data[0];  // arm only an idle group
        end else if (dp2reg_done && consumer == i[0]) begin
          op_en[i] <= 1'b0;
        end
      end
      if (dp2reg_done) begin
        consumer <= ~consumer;
      end
    end
  end

  assign d0_op_en     = op_en[0];
  assign d1_op_en     = op_en[1];
  assign active_op_en = op_en[consumer];

  // done flushes the pipe so the next group restarts cleanly
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_dly <= '0;
    end else if (dp2reg_done) begin
      op_en_dly <= '0;
    end else begin
      op_en_dly <= {op_en_dly[`CSC_OP_EN_DELAY-2:0], active_op_en};
    end
  end

  assign reg2dp_op_en = op_en_dly[`CSC_OP_EN_DELAY-1];

  ////////////////////
  // active field select
  assign reg2dp_conv_mode         = consumer ? d1_conv_mode : d0_conv_mode;
  assign reg2dp_in_precision      = consumer ? d1_in_precision : d0_in_precision;
  assign reg2dp_datain_width_ext  = consumer ? d1_datain_width_ext : d0_datain_width_ext;
  assign reg2dp_datain_height_ext = consumer ? d1_datain_height_ext : d0_datain_height_ext;
  assign reg2dp_weight_bytes      = consumer ? d1_weight_bytes : d0_weight_bytes;

  // datapath only finishes a group that was armed
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dp2reg_done |-> active_op_en)
    else $error("csc_group_ctrl: done while consumer group is not armed");

endmodule

`default_nettype wire

// File: logic/csc_reg_access.sv
// access decode of the csc register file
// routes each access to the single group or to the dual group
// named by the producer, and merges the read data back
`default_nettype none
`timescale 1ns/100ps
`include "csc_regfile_macros.svh"

module csc_reg_access (
  input  wire csc_regfile_pkg::reg_offset_t reg_offset,
  input  wire                               reg_wr_en,
  input  wire                               producer,
  input  wire                               d0_op_en,
  input  wire                               d1_op_en,
  input  wire csc_regfile_pkg::reg_data_t   s_rd_data,
  input  wire csc_regfile_pkg::reg_data_t   d0_rd_data,
  input  wire csc_regfile_pkg::reg_data_t   d1_rd_data,
  output logic                              s_wr_en,
  output logic                              d0_wr_en,
  output logic                              d1_wr_en,
  output csc_regfile_pkg::reg_data_t        reg_rd_data
);

  logic select_s;
  logic select_d0;
  logic select_d1;

  always_comb begin
    select_s  = (reg_offset < `CSC_GROUP_BASE);
    select_d0 = ~select_s & ~producer;
    select_d1 = ~select_s & producer;
  end

  // an armed group keeps its config
  assign s_wr_en  = reg_wr_en & select_s;
  assign d0_wr_en = reg_wr_en & select_d0 & ~d0_op_en;
  assign d1_wr_en = reg_wr_en & select_d1 & ~d1_op_en;

  assign reg_rd_data = ({32{select_s}}  & s_rd_data)  |
                       ({32{select_d0}} & d0_rd_data) |
                       ({32{select_d1}} & d1_rd_data);

endmodule

`default_nettype wire

// File: logic/csc_regfile.sv
// csc register file top
// CSB port, access decode, single and ping-pong groups,
// group control toward the convolution datapath
`default_nettype none
`timescale 1ns/100ps

module csc_regfile (
  input  wire                                 nvdla_core_clk,
  input  wire                                 nvdla_core_rstn,
  input  wire                                 csb2csc_req_pvld,
  input  wire csc_regfile_pkg::csb_req_pd_t   csb2csc_req_pd,
  input  wire                                 dp2reg_done,
  output wire                                 csc2csb_resp_valid,
  output wire csc_regfile_pkg::csb_resp_pd_t  csc2csb_resp_pd,
  output wire                                 reg2dp_op_en,
  output wire                                 reg2dp_conv_mode,
  output wire csc_regfile_pkg::precision_t    reg2dp_in_precision,
  output wire csc_regfile_pkg::dim_ext_t      reg2dp_datain_width_ext,
  output wire csc_regfile_pkg::dim_ext_t      reg2dp_datain_height_ext,
  output wire csc_regfile_pkg::weight_bytes_t reg2dp_weight_bytes
);

  wire csc_regfile_pkg::reg_offset_t   reg_offset;
  wire csc_regfile_pkg::reg_data_t     reg_wr_data;
  wire                                 reg_wr_en;
  wire csc_regfile_pkg::reg_data_t     reg_rd_data;
  wire                                 s_wr_en;
  wire                                 d0_wr_en;
  wire                                 d1_wr_en;
  wire csc_regfile_pkg::reg_data_t     s_rd_data;
  wire csc_regfile_pkg::reg_data_t     d0_rd_data;
  wire csc_regfile_pkg::reg_data_t     d1_rd_data;
  wire                                 producer;
  wire                                 consumer;
  wire                                 d0_op_en;
  wire                                 d1_op_en;
  wire                                 d0_op_en_trigger;
  wire                                 d1_op_en_trigger;
  wire                                 d0_conv_mode;
  wire csc_regfile_pkg::precision_t    d0_in_precision;
  wire csc_regfile_pkg::dim_ext_t      d0_datain_width_ext;
  wire csc_regfile_pkg::dim_ext_t      d0_datain_height_ext;
  wire csc_regfile_pkg::weight_bytes_t d0_weight_bytes;
  wire                                 d1_conv_mode;
  wire csc_regfile_pkg::precision_t    d1_in_precision;
  wire csc_regfile_pkg::dim_ext_t      d1_datain_width_ext;
  wire csc_regfile_pkg::dim_ext_t      d1_datain_height_ext;
  wire csc_regfile_pkg::weight_bytes_t d1_weight_bytes;

  csc_csb_port u_csb_port (.*);  // request in, response out

  csc_reg_access u_reg_access (.*);

  csc_single_reg u_single_reg (.*);

  ////////////////////
  // ping-pong groups
  csc_dual_reg u_dual_reg_d0 (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_offset, .reg_wr_data,
    .wr_en             (d0_wr_en),
    .op_en             (d0_op_en),
    .op_en_trigger     (d0_op_en_trigger),
    .rd_data           (d0_rd_data),
    .conv_mode         (d0_conv_mode),
    .in_precision      (d0_in_precision),
    .datain_width_ext  (d0_datain_width_ext),
    .datain_height_ext (d0_datain_height_ext),
    .weight_bytes      (d0_weight_bytes)
  );

  csc_dual_reg u_dual_reg_d1 (
    .nvdla_core_clk, .nvdla_core_rstn, .reg_offset, .reg_wr_data,
    .wr_en             (d1_wr_en),
    .op_en             (d1_op_en),
    .op_en_trigger     (d1_op_en_trigger),
    .rd_data           (d1_rd_data),
    .conv_mode         (d1_conv_mode),
    .in_precision      (d1_in_precision),
    .datain_width_ext  (d1_datain_width_ext),
    .datain_height_ext (d1_datain_height_ext),
    .weight_bytes      (d1_weight_bytes)
  );

  csc_group_ctrl u_group_ctrl (.*);  // consumer side and reg2dp outputs

endmodule

`default_nettype wire

// File: logic/csc_regfile_macros.svh
// csc register file constants
// register offsets, csb packet fields and op_en delay depth
`ifndef CSC_REGFILE_MACROS_SVH
`define CSC_REGFILE_MACROS_SVH

// single group
`define CSC_S_POINTER      12'h000  // producer bit 0, consumer bit 16
`define CSC_S_STATUS       12'h004
// dual groups
`define CSC_D_OP_ENABLE    12'h008
`define CSC_D_MISC_CFG     12'h00c
`define CSC_D_DATAIN_SIZE  12'h010
`define CSC_D_WEIGHT_BYTES 12'h014

`define CSC_GROUP_BASE     12'h008  // first dual group offset

// csb request packet
`define CSC_REQ_ADDR       21:0  // word address
`define CSC_REQ_WDAT       53:22
`define CSC_REQ_WRITE      54
`define CSC_REQ_NPOSTED    55
`define CSC_RESP_IS_WRITE  33

`define CSC_OP_EN_DELAY    3

`endif

// File: logic/csc_regfile_pkg.sv
// csc register file types
// csb packet, register data and datapath field widths
`default_nettype none

package csc_regfile_pkg;

  typedef logic [62:0] csb_req_pd_t;
  typedef logic [33:0] csb_resp_pd_t;
  typedef logic [11:0] reg_offset_t;  // byte offset in the 4KB space
  typedef logic [31:0] reg_data_t;

  typedef logic [12:0] dim_ext_t;  // size minus one
  typedef logic [24:0] weight_bytes_t;
  typedef logic [1:0]  precision_t;

  // per group status as read from S_STATUS
  typedef enum logic [1:0] {
    status_idle    = 2'd0,
    status_running = 2'd1,
    status_pending = 2'd2
  } group_status_e;

endpackage

`default_nettype wire

// File: logic/csc_single_reg.sv
// single register group of the csc register file
// producer pointer plus pointer and status read-back
`default_nettype none
`timescale 1ns/100ps
`include "csc_regfile_macros.svh"

module csc_single_reg (
  input  wire                               nvdla_core_clk,
  input  wire                               nvdla_core_rstn,
  input  wire csc_regfile_pkg::reg_offset_t reg_offset,
  input  wire csc_regfile_pkg::reg_data_t   reg_wr_data,
  input  wire                               s_wr_en,
  input  wire                               consumer,
  input  wire                               d0_op_en,
  input  wire                               d1_op_en,
  output logic                              producer,
  output csc_regfile_pkg::reg_data_t        s_rd_data
);

  csc_regfile_pkg::group_status_e status_0;
  csc_regfile_pkg::group_status_e status_1;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (s_wr_en && reg_offset == `CSC_S_POINTER) begin
      producer <= reg_wr_data[0];
    end
  end

  // armed group is running when the consumer points at it
  assign status_0 = !d0_op_en ? csc_regfile_pkg::status_idle :
                    consumer  ? csc_regfile_pkg::status_pending :
                                csc_regfile_pkg::status_running;
  assign status_1 = !d1_op_en ? csc_regfile_pkg::status_idle :
                    consumer  ? csc_regfile_pkg::status_running :
                                csc_regfile_pkg::status_pending;

  always_comb begin
    case (reg_offset)
      `CSC_S_POINTER: s_rd_data = {15'd0, consumer, 15'd0, producer};
      `CSC_S_STATUS:  s_rd_data = {14'd0, status_1, 14'd0, status_0};
      default:        s_rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: testbench/csc_regfile_cases.txt
# columns: kind offset(hex) data(hex) expected(hex, 34 bit response or value) name
# kinds: wp/wn posted/non-posted write, rd read, dn done, ck output (offset 0..5 = op_en conv prec w h bytes)
rd 000 00000000 000000000 reset_pointer
rd 004 00000000 000000000 reset_status
ck 000 00000000 000000000 reset_op_en
wp 00c fffffe01 000000000 g0_misc_wr
wp 010 e456e123 000000000 g0_size_wr
wp 014 fe123456 000000000 g0_bytes_wr
rd 00c 00000000 000000201 g0_misc_rd
rd 010 00000000 004560123 g0_size_rd
rd 014 00000000 000123456 g0_bytes_rd
rd 018 00000000 000000000 unknown_offset_rd
ck 001 00000000 000000001 g0_dp_conv_mode
ck 002 00000000 000000002 g0_dp_precision
ck 003 00000000 000000123 g0_dp_width
ck 004 00000000 000000456 g0_dp_height
ck 005 00000000 000123456 g0_dp_bytes
wn 000 00000001 200000000 producer_g1_wr
wp 00c 00000100 000000000 g1_misc_wr
wp 010 00ff0077 000000000 g1_size_wr
wp 014 01000001 000000000 g1_bytes_wr
rd 00c 00000000 000000100 g1_misc_rd
rd 010 00000000 000ff0077 g1_size_rd
rd 014 00000000 001000001 g1_bytes_rd
ck 001 00000000 000000001 dp_still_g0_conv
ck 005 00000000 000123456 dp_still_g0_bytes
wp 000 00000000 000000000 producer_g0_wr
wp 008 00000001 000000000 g0_arm_wr
wp 000 00000001 000000000 producer_g1_again_wr
wn 008 00000001 200000000 g1_arm_wr
ck 000 00000000 000000001 op_en_rise
rd 004 00000000 000020001 armed_status_rd
wp 00c 00000001 000000000 g1_locked_wr
rd 00c 00000000 000000100 g1_locked_rd
rd 008 00000000 000000001 g1_op_en_rd
dn 000 00000000 000000000 done_pulse
ck 000 00000000 000000000 done_op_en_low
rd 000 00000000 000010001 done_pointer_rd
rd 004 00000000 000010000 done_status_rd
ck 001 00000000 000000000 g1_dp_conv_mode
ck 002 00000000 000000001 g1_dp_precision
ck 003 00000000 000000077 g1_dp_width
ck 004 00000000 0000000ff g1_dp_height
ck 005 00000000 001000001 g1_dp_bytes
ck 000 00000000 000000001 op_en_second_rise

// File: testbench/tb_csc_regfile.sv
// testbench for the csc register file
// replays the case file over CSB and checks read-back, responses
// and the reg2dp outputs against the expected column
`default_nettype none
`timescale 1ns/100ps
`include "csc_regfile_macros.svh"

module tb_csc_regfile;

  logic                           nvdla_core_clk;
  logic                           nvdla_core_rstn;
  logic                           csb2csc_req_pvld;
  csc_regfile_pkg::csb_req_pd_t   csb2csc_req_pd;
  logic                           dp2reg_done;
  logic                           csc2csb_resp_valid;
  csc_regfile_pkg::csb_resp_pd_t  csc2csb_resp_pd;
  logic                           reg2dp_op_en;
  logic                           reg2dp_conv_mode;
  csc_regfile_pkg::precision_t    reg2dp_in_precision;
  csc_regfile_pkg::dim_ext_t      reg2dp_datain_width_ext;
  csc_regfile_pkg::dim_ext_t      reg2dp_datain_height_ext;
  csc_regfile_pkg::weight_bytes_t reg2dp_weight_bytes;

  csc_regfile u_dut (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #20 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////
  // error and compare tasks
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_resp(input string name, input csc_regfile_pkg::csb_resp_pd_t exp,
                            input csc_regfile_pkg::csb_resp_pd_t act);
    if (act !== exp) stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_data(input string name, input csc_regfile_pkg::reg_data_t exp,
                            input csc_regfile_pkg::reg_data_t act);
    if (act !== exp) stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_dim(input string name, input csc_regfile_pkg::dim_ext_t exp,
                           input csc_regfile_pkg::dim_ext_t act);
    if (act !== exp) stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_bytes(input string name, input csc_regfile_pkg::weight_bytes_t exp,
                             input csc_regfile_pkg::weight_bytes_t act);
    if (act !== exp) stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_precision(input string name, input csc_regfile_pkg::precision_t exp,
                                 input csc_regfile_pkg::precision_t act);
    if (act !== exp) stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_op_en(input string name, input logic exp, input logic act);
    if (act !== exp) stop_on_error($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
  endtask

  ////////////////////
  // bus and datapath drivers
  task automatic send_request(input logic write, input logic nposted,
                              input csc_regfile_pkg::reg_offset_t offset,
                              input csc_regfile_pkg::reg_data_t data);
    @(posedge nvdla_core_clk);
    #2;
    csb2csc_req_pd                   = '0;
    csb2csc_req_pd[`CSC_REQ_ADDR]    = {12'd0, offset[11:2]};  // byte to word address
    csb2csc_req_pd[`CSC_REQ_WDAT]    = data;
    csb2csc_req_pd[`CSC_REQ_WRITE]   = write;
    csb2csc_req_pd[`CSC_REQ_NPOSTED] = nposted;
    csb2csc_req_pvld                 = 1'b1;
    @(posedge nvdla_core_clk);
    #2;
    csb2csc_req_pvld = 1'b0;
  endtask

  task automatic wait_response(input string name, output csc_regfile_pkg::csb_resp_pd_t pd);
    int cycles;
    cycles = 0;
    while (!csc2csb_resp_valid && cycles < 20) begin
      @(posedge nvdla_core_clk);
      #2;
      cycles++;
    end
    if (!csc2csb_resp_valid)
      stop_on_error($sformatf("%s: no response arrived within 20 cycles", name));
    pd = csc2csb_resp_pd;
  endtask

  task automatic expect_no_response(input string name);
    for (int i = 0; i < 20; i++) begin
      @(posedge nvdla_core_clk);
      #2;
      if (csc2csb_resp_valid)
        stop_on_error($sformatf("%s: a posted write got a response", name));
    end
  endtask

  task automatic wait_op_en_high(input string name);
    int cycles;
    cycles = 0;
    while (reg2dp_op_en !== 1'b1 && cycles < 20) begin
      @(posedge nvdla_core_clk);
      #2;
      cycles++;
    end
    if (reg2dp_op_en !== 1'b1)
      stop_on_error($sformatf("%s: reg2dp_op_en did not rise within 20 cycles", name));
  endtask

  task automatic pulse_done();
    @(posedge nvdla_core_clk);
    #2;
    dp2reg_done = 1'b1;
    @(posedge nvdla_core_clk);
    #2;
    dp2reg_done = 1'b0;
  endtask

  task automatic idle_gap();
    int unsigned gap;
    gap = $urandom % 4;
    repeat (gap) @(posedge nvdla_core_clk);
  endtask

  ////////////////////
  // case replay
  initial begin
    int                            fd;
    int                            num_ops;
    string                         line;
    string                         kind;
    string                         name;
    logic [11:0]                   off_raw;
    logic [31:0]                   data_raw;
    logic [35:0]                   exp_raw;
    csc_regfile_pkg::csb_resp_pd_t resp;

    nvdla_core_rstn  = 1'b0;
    csb2csc_req_pvld = 1'b0;
    csb2csc_req_pd   = '0;
    dp2reg_done      = 1'b0;
    num_ops          = 0;
    void'($urandom(18));

    fd = $fopen("testbench/csc_regfile_cases.txt", "r");
    if (fd == 0) stop_on_error("could not open the case file testbench/csc_regfile_cases.txt");

    repeat (2) @(posedge nvdla_core_clk);
    #2;
    nvdla_core_rstn = 1'b1;

    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) continue;
      if (line.len() == 0 || line.getc(0) == "#") continue;  // comment or blank
      if ($sscanf(line, "%s %h %h %h %s", kind, off_raw, data_raw, exp_raw, name) != 5) continue;
      num_ops++;
      if (kind != "ck") idle_gap();  // output checks follow their operation directly
      if (kind == "wp") begin
        send_request(1'b1, 1'b0, off_raw, data_raw);
        expect_no_response(name);
      end else if (kind == "wn") begin
        send_request(1'b1, 1'b1, off_raw, data_raw);
        wait_response(name, resp);
        check_resp(name, exp_raw[33:0], resp);
      end else if (kind == "rd") begin
        send_request(1'b0, 1'b0, off_raw, '0);
        wait_response(name, resp);
        check_data(name, exp_raw[31:0], resp[31:0]);
        check_resp(name, {2'b00, exp_raw[31:0]}, resp);  // read flag stays low
      end else if (kind == "dn") begin
        pulse_done();
      end else if (kind == "ck") begin
        case (off_raw)
          12'h000: begin
            if (exp_raw[0]) wait_op_en_high(name);
            check_op_en(name, exp_raw[0], reg2dp_op_en);
          end
          12'h001: check_op_en(name, exp_raw[0], reg2dp_conv_mode);
          12'h002: check_precision(name, exp_raw[1:0], reg2dp_in_precision);
          12'h003: check_dim(name, exp_raw[12:0], reg2dp_datain_width_ext);
          12'h004: check_dim(name, exp_raw[12:0], reg2dp_datain_height_ext);
          12'h005: check_bytes(name, exp_raw[24:0], reg2dp_weight_bytes);
          default: stop_on_error($sformatf("%s: unknown output code %h", name, off_raw));
        endcase
      end else begin
        stop_on_error($sformatf("%s: unknown operation kind %s", name, kind));
      end
    end
    $fclose(fd);

    if (num_ops == 0) begin
      stop_on_error("the case file held no operations");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
